// File: list.f
+incdir+.
lsq_entry_pkg.sv
lsq_bus_pkg.sv
store_queue.sv
load_buffer.sv
store_forward.sv
lsq_mem_control.sv
lsq_top.sv
lsq_checker.sv
lsq_tb.sv

// File: load_buffer.sv
`include "lsq_params.svh"

module load_buffer import lsq_entry_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      lb_alloc,
    input  logic      lb_resolve,
    input  lb_idx_t   lb_resolve_idx,
    input  word_t     lb_resolve_addr,
    input  load_tag_t lb_resolve_tag,
    input  sq_idx_t   sq_alloc_idx,
    input  sq_idx_t   sq_head,
    input  sq_idx_t   oldest_unresolved,
    input  logic      all_resolved,
    input  logic      issue_ready,
    output lb_idx_t   lb_alloc_idx,
    output logic      lb_full,
    output logic      issue_valid,
    output word_t     issue_addr,
    output sq_idx_t   issue_age,
    output load_tag_t issue_tag
);

    lb_slot_state_t slot_state [`LSQ_LB_DEPTH];
    word_t          slot_addr  [`LSQ_LB_DEPTH];
    load_tag_t      slot_tag   [`LSQ_LB_DEPTH];
    sq_idx_t        slot_age   [`LSQ_LB_DEPTH];

    sq_idx_t                   unresolved_dist;
    logic [`LSQ_LB_DEPTH-1:0]  safe;
    lb_idx_t                   free_idx;
    logic                      free_valid;
    lb_idx_t                   pick_idx;
    logic                      pick_valid;

    ////////////////////////////////////////////////////////////
    // Age safety and slot selection
    ////////////////////////////////////////////////////////////

    // Distances are counted from the store head around the ring
    assign unresolved_dist = sq_idx_t'(oldest_unresolved - sq_head);

    always_comb begin
        for (int j = 0; j < `LSQ_LB_DEPTH; j++) begin
            safe[j] = slot_state[j] == RESOLVED &&
                      (all_resolved || sq_idx_t'(slot_age[j] - sq_head) <= unresolved_dist);
        end
    end

    // Lowest index wins for both allocation and issue
    always_comb begin
        free_idx   = '0;
        free_valid = 1'b0;
        pick_idx   = '0;
        pick_valid = 1'b0;
        for (int j = `LSQ_LB_DEPTH - 1; j >= 0; j--) begin
            if (slot_state[j] == FREE) begin
                free_idx   = lb_idx_t'(j);
                free_valid = 1'b1;
            end
            if (safe[j]) begin
                pick_idx   = lb_idx_t'(j);
                pick_valid = 1'b1;
            end
        end
    end

    assign lb_alloc_idx = free_idx;
    assign lb_full      = !free_valid;

    ////////////////////////////////////////////////////////////
    // Slot state and issue register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int j = 0; j < `LSQ_LB_DEPTH; j++) begin
                slot_state[j] <= FREE;
            end
            issue_valid <= 1'b0;
        end else begin
            if (lb_alloc && free_valid) begin
                slot_state[free_idx] <= WAITING;
            end
            if (lb_resolve && slot_state[lb_resolve_idx] == WAITING) begin
                slot_state[lb_resolve_idx] <= RESOLVED;
            end
            // issue_ready means the current issue is taken this cycle
            if (issue_ready) begin
                issue_valid <= pick_valid;
                if (pick_valid) begin
                    slot_state[pick_idx] <= FREE;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (lb_alloc) begin
            slot_age[free_idx] <= sq_alloc_idx;
        end
        if (lb_resolve) begin
            slot_addr[lb_resolve_idx] <= lb_resolve_addr;
            slot_tag[lb_resolve_idx]  <= lb_resolve_tag;
        end
        if (issue_ready && pick_valid) begin
            issue_addr <= slot_addr[pick_idx];
            issue_age  <= slot_age[pick_idx];
            issue_tag  <= slot_tag[pick_idx];
        end
    end

    a_resolve_waiting: assert property (
        @(posedge clock) disable iff (reset) lb_resolve |-> slot_state[lb_resolve_idx] == WAITING);

    a_no_alloc_when_full: assert property (
        @(posedge clock) disable iff (reset) lb_alloc |-> !lb_full);

endmodule

// File: lsq_bus_pkg.sv
package lsq_bus_pkg;

    // Kind of memory access in flight, none for a forwarded load
    typedef enum logic [1:0] {
        OP_NONE,
        OP_STORE,
        OP_LOAD
    } mem_op_t;

    // Wishbone master control
    typedef enum logic [1:0] {
        IDLE,
        STORE_CYCLE,
        LOAD_CYCLE,
        RESPOND
    } wb_state_t;

endpackage

// File: lsq_checker.sv
`include "lsq_params.svh"

module lsq_checker import lsq_entry_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      cmd_valid,
    input  int        cmd_line,
    input  logic      sq_alloc,
    input  sq_idx_t   sq_alloc_idx,
    input  logic      lb_alloc,
    input  lb_idx_t   lb_alloc_idx,
    input  logic      lb_resolve,
    input  lb_idx_t   lb_resolve_idx,
    input  load_tag_t lb_resolve_tag,
    input  logic      result_valid,
    input  load_tag_t result_tag,
    input  word_t     result_data,
    input  logic      result_forwarded,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  logic      wb_ack,
    input  word_t     wb_addr,
    input  word_t     wb_write_data,
    input  logic      sq_full,
    input  logic      lb_full,
    output logic      all_done,
    output int        tests_run,
    output int        tests_failed,
    output int        error_count
);

    localparam int MAX_LINES = 64;
    localparam int NUM_TAGS  = 1 << `LSQ_TAG_LEN;

    localparam int CMD_EXPECT_RESULT = 7;
    localparam int CMD_EXPECT_WRITE  = 8;
    localparam int CMD_FULL_FLAGS    = 9;
    localparam int CMD_END_TEST      = 10;

    logic [31:0] cmd_mem [0:4*MAX_LINES-1];
    logic        pending [NUM_TAGS];
    word_t       expect_data [NUM_TAGS];
    logic        expect_fwd [NUM_TAGS];
    int          pending_results;
    word_t       write_addr_q [$];
    word_t       write_data_q [$];
    int          test_errors;

    // Slot use as seen from outside, a slot stays RESOLVED until its result
    lb_slot_state_t slot_model [`LSQ_LB_DEPTH];
    load_tag_t      slot_tag [`LSQ_LB_DEPTH];
    sq_idx_t        store_tail;

    initial begin
        $readmemh("lsq_testdata.txt", cmd_mem);
        for (int t = 0; t < NUM_TAGS; t++) begin
            pending[t] = 1'b0;
        end
        for (int j = 0; j < `LSQ_LB_DEPTH; j++) begin
            slot_model[j] = FREE;
            slot_tag[j]   = '0;
        end
        store_tail      = '0;
        pending_results = 0;
        test_errors     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        error_count     = 0;
        all_done        = 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input word_t got, input word_t expected);
        $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, expected);
        test_errors++;
        error_count++;
    endtask

    task automatic report_failure(input string text);
        $display("Failure at %0t: %s", $time, text);
        test_errors++;
        error_count++;
    endtask

    ////////////////////////////////////////////////////////////
    // Result, bus write and command handling
    ////////////////////////////////////////////////////////////

    // A result for a tag that is not yet expected came too early
    task automatic check_result();
        for (int j = 0; j < `LSQ_LB_DEPTH; j++) begin
            if (slot_model[j] == RESOLVED && slot_tag[j] == result_tag) begin
                slot_model[j] = FREE;
            end
        end
        if (!pending[result_tag]) begin
            report_failure($sformatf("result for load tag %0d came when none was expected",
                                     result_tag));
        end else begin
            if (result_data !== expect_data[result_tag]) begin
                report_mismatch("result_data", result_data, expect_data[result_tag]);
            end
            if (result_forwarded !== expect_fwd[result_tag]) begin
                report_mismatch("result_forwarded", word_t'(result_forwarded),
                                word_t'(expect_fwd[result_tag]));
            end
            pending[result_tag] = 1'b0;
            pending_results--;
        end
    endtask

    // Writes must leave in program order
    task automatic check_write();
        word_t exp_addr;
        word_t exp_data;
        if (write_addr_q.size() == 0) begin
            report_failure($sformatf("bus write of %h to %h was not expected",
                                     wb_write_data, wb_addr));
        end else begin
            exp_addr = write_addr_q.pop_front();
            exp_data = write_data_q.pop_front();
            if (wb_addr !== exp_addr) begin
                report_mismatch("wb_addr", wb_addr, exp_addr);
            end
            if (wb_write_data !== exp_data) begin
                report_mismatch("wb_write_data", wb_write_data, exp_data);
            end
        end
    endtask

    // Stores take the tail in turn, loads the lowest slot that can be free
    task automatic check_alloc_index();
        lb_idx_t lowest;
        logic    found;
        if (sq_alloc) begin
            if (sq_alloc_idx !== store_tail) begin
                report_mismatch("sq_alloc_idx", word_t'(sq_alloc_idx), word_t'(store_tail));
            end
            store_tail = store_tail + 1'b1;
        end
        if (lb_alloc) begin
            lowest = '0;
            found  = 1'b0;
            for (int j = `LSQ_LB_DEPTH - 1; j >= 0; j--) begin
                if (slot_model[j] == FREE) begin
                    lowest = lb_idx_t'(j);
                    found  = 1'b1;
                end
            end
            if (slot_model[lb_alloc_idx] == WAITING) begin
                report_failure($sformatf("load slot %0d was handed out while still allocated",
                                         lb_alloc_idx));
            end else if (found && lb_alloc_idx > lowest) begin
                report_mismatch("lb_alloc_idx", word_t'(lb_alloc_idx), word_t'(lowest));
            end
            slot_model[lb_alloc_idx] = WAITING;
        end
        if (lb_resolve) begin
            slot_model[lb_resolve_idx] = RESOLVED;
            slot_tag[lb_resolve_idx]   = lb_resolve_tag;
        end
    endtask

    task automatic end_test(input int number);
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (pending[t]) begin
                report_failure($sformatf("test %0d saw no result for load tag %0d", number, t));
                pending[t] = 1'b0;
            end
        end
        if (write_addr_q.size() != 0) begin
            report_failure($sformatf("test %0d is missing %0d expected bus writes",
                                     number, write_addr_q.size()));
            write_addr_q.delete();
            write_data_q.delete();
        end
        pending_results = 0;
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0d passed", number);
        end else begin
            $display("Test %0d failed with %0d errors", number, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic take_command();
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        op = cmd_mem[4*cmd_line];
        a  = cmd_mem[4*cmd_line+1];
        b  = cmd_mem[4*cmd_line+2];
        c  = cmd_mem[4*cmd_line+3];
        case (op)
            CMD_EXPECT_RESULT: begin
                pending[load_tag_t'(a)]     = 1'b1;
                expect_data[load_tag_t'(a)] = b;
                expect_fwd[load_tag_t'(a)]  = c[0];
                pending_results++;
            end
            CMD_EXPECT_WRITE: begin
                write_addr_q.push_back(a);
                write_data_q.push_back(b);
            end
            CMD_FULL_FLAGS: begin
                if (sq_full !== a[0]) begin
                    report_mismatch("sq_full", word_t'(sq_full), word_t'(a[0]));
                end
                if (lb_full !== b[0]) begin
                    report_mismatch("lb_full", word_t'(lb_full), word_t'(b[0]));
                end
            end
            CMD_END_TEST: begin
                end_test(a);
            end
            default: begin
            end
        endcase
    endtask

    always @(posedge clock) begin
        if (!reset) begin
            if (result_valid) begin
                check_result();
            end
            if (wb_cyc && wb_stb && wb_we && wb_ack) begin
                check_write();
            end
            check_alloc_index();
            if (cmd_valid) begin
                take_command();
            end
        end
        all_done = pending_results == 0 && write_addr_q.size() == 0;
    end

endmodule

// File: lsq_entry_pkg.sv
`include "lsq_params.svh"

package lsq_entry_pkg;

    // Store queue position, also the age of a load
    typedef logic [`LSQ_SQ_IDX_LEN-1:0] sq_idx_t;

    // Occupancy up to and including a full queue
    typedef logic [$clog2(`LSQ_SQ_DEPTH + 1)-1:0] sq_count_t;

    typedef logic [`LSQ_LB_IDX_LEN-1:0] lb_idx_t;

    // Names the destination of a load result
    typedef logic [`LSQ_TAG_LEN-1:0] load_tag_t;

    typedef logic [`LSQ_XLEN-1:0] word_t;

    // Lifetime of a load slot
    typedef enum logic [1:0] {
        FREE,
        WAITING,
        RESOLVED
    } lb_slot_state_t;

endpackage

// File: lsq_mem_control.sv
`include "lsq_params.svh"

module lsq_mem_control import lsq_entry_pkg::*, lsq_bus_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      drain_ready,
    input  word_t     drain_addr,
    input  word_t     drain_data,
    input  logic      issue_valid,
    input  word_t     issue_addr,
    input  load_tag_t issue_tag,
    input  logic      fwd_match,
    input  word_t     fwd_data,
    input  logic      wb_ack,
    input  word_t     wb_read_data,
    output logic      drain_done,
    output logic      issue_ready,
    output logic      wb_cyc,
    output logic      wb_stb,
    output logic      wb_we,
    output word_t     wb_addr,
    output word_t     wb_write_data,
    output logic      result_valid,
    output load_tag_t result_tag,
    output word_t     result_data,
    output logic      result_forwarded
);

    wb_state_t state;
    mem_op_t   op;

    // Loads are only taken when no drain is waiting
    assign issue_ready = state == IDLE && !drain_ready;

    assign wb_cyc     = state == STORE_CYCLE || state == LOAD_CYCLE;
    assign wb_stb     = wb_cyc;
    assign wb_we      = wb_cyc && op == OP_STORE;
    assign drain_done = state == STORE_CYCLE && wb_ack;

    assign result_valid     = state == RESPOND;
    assign result_forwarded = result_valid && op == OP_NONE;

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
            op    <= OP_NONE;
        end else begin
            case (state)
                IDLE: begin
                    if (drain_ready) begin
                        state <= STORE_CYCLE;
                        op    <= OP_STORE;
                    end else if (issue_valid && fwd_match) begin
                        state <= RESPOND;
                        op    <= OP_NONE;
                    end else if (issue_valid) begin
                        state <= LOAD_CYCLE;
                        op    <= OP_LOAD;
                    end
                end
                STORE_CYCLE: begin
                    if (wb_ack) begin
                        state <= IDLE;
                    end
                end
                LOAD_CYCLE: begin
                    if (wb_ack) begin
                        state <= RESPOND;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Bus address and data are held for the whole cycle
    always_ff @(posedge clock) begin
        if (state == IDLE) begin
            if (drain_ready) begin
                wb_addr       <= drain_addr;
                wb_write_data <= drain_data;
            end else if (issue_valid) begin
                wb_addr     <= issue_addr;
                result_tag  <= issue_tag;
                result_data <= fwd_data;
            end
        end
        if (state == LOAD_CYCLE && wb_ack) begin
            result_data <= wb_read_data;
        end
    end

    // Cycle and strobe drop in the clock after the acknowledge
    a_drop_after_ack: assert property (
        @(posedge clock) disable iff (reset) wb_stb && wb_ack |=> !wb_cyc && !wb_stb);

    // Classic cycle stays up and stable until acknowledged
    a_hold_until_ack: assert property (
        @(posedge clock) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_addr) && $stable(wb_we));

endmodule

// File: lsq_params.svh
`ifndef LSQ_PARAMS_SVH
`define LSQ_PARAMS_SVH

// Queue depths
`define LSQ_SQ_DEPTH 8
`define LSQ_LB_DEPTH 4

// Word and tag widths
`define LSQ_XLEN 32
`define LSQ_TAG_LEN 6

// log2 of the depths above
`define LSQ_SQ_IDX_LEN 3
`define LSQ_LB_IDX_LEN 2

`endif

// File: lsq_tb.sv
module lsq_tb import lsq_entry_pkg::*; ();

    localparam int CLOCK_PERIOD    = 10;
    localparam int MAX_LINES       = 64;
    localparam int TEST_LIMIT      = 150;
    localparam int CYCLES_PER_LINE = 200;

    // Command codes of the data file
    localparam int CMD_STORE_ALLOC   = 1;
    localparam int CMD_STORE_RESOLVE = 2;
    localparam int CMD_COMMIT        = 3;
    localparam int CMD_LOAD_ALLOC    = 4;
    localparam int CMD_LOAD_RESOLVE  = 5;
    localparam int CMD_WAIT          = 6;
    localparam int CMD_END_TEST      = 10;
    localparam int CMD_STOP          = 15;

    logic      clock;
    logic      reset;
    logic      sq_alloc;
    sq_idx_t   sq_alloc_idx;
    logic      sq_full;
    logic      sq_resolve;
    sq_idx_t   sq_resolve_idx;
    word_t     sq_resolve_addr;
    word_t     sq_resolve_data;
    logic      store_commit;
    logic      lb_alloc;
    lb_idx_t   lb_alloc_idx;
    logic      lb_full;
    logic      lb_resolve;
    lb_idx_t   lb_resolve_idx;
    word_t     lb_resolve_addr;
    load_tag_t lb_resolve_tag;
    logic      result_valid;
    load_tag_t result_tag;
    word_t     result_data;
    logic      result_forwarded;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    word_t     wb_addr;
    word_t     wb_write_data;
    word_t     wb_read_data = '0;
    logic      wb_ack = 1'b0;

    logic        cmd_valid;
    int          cmd_line;
    logic        all_done;
    int          tests_run;
    int          tests_failed;
    int          error_count;
    logic [31:0] cmd_mem [0:4*MAX_LINES-1];
    int          num_lines;
    logic        lines_ready;

    // Memory model state
    word_t  mem [word_t];
    int     bus_wait = -1;
    integer seed = 32'he5cf_884d;

    lsq_top i_lsq_top (.*);

    lsq_checker i_lsq_checker (.*);

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////////////////////////
    // Wishbone memory model
    ////////////////////////////////////////////////////////////

    // Untouched words read back as a pattern of their address
    function automatic word_t read_word(input word_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr ^ 32'h5a5a_0000;
    endfunction

    always @(negedge clock) begin
        if (reset || wb_ack) begin
            wb_ack   = 1'b0;
            bus_wait = -1;
        end else if (wb_cyc && wb_stb) begin
            // New cycle draws 0 to 3 wait states
            if (bus_wait < 0) begin
                bus_wait = $random(seed) & 3;
            end
            if (bus_wait == 0) begin
                wb_ack = 1'b1;
                if (wb_we) begin
                    mem[wb_addr] = wb_write_data;
                end else begin
                    wb_read_data = read_word(wb_addr);
                end
            end else begin
                bus_wait--;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Command driver
    ////////////////////////////////////////////////////////////

    // Single-cycle pulses drop at every falling edge
    task automatic next_cycle();
        @(negedge clock);
        sq_alloc     = 1'b0;
        sq_resolve   = 1'b0;
        store_commit = 1'b0;
        lb_alloc     = 1'b0;
        lb_resolve   = 1'b0;
        cmd_valid    = 1'b0;
    endtask

    task automatic wait_for_checker();
        int waited;
        waited = 0;
        while (!all_done && waited < TEST_LIMIT) begin
            next_cycle();
            waited++;
        end
    endtask

    task automatic run_command(input int cmd_index);
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        int          k;
        op = cmd_mem[4*cmd_index];
        a  = cmd_mem[4*cmd_index+1];
        b  = cmd_mem[4*cmd_index+2];
        c  = cmd_mem[4*cmd_index+3];
        next_cycle();
        if (op == CMD_END_TEST) begin
            wait_for_checker();
        end
        cmd_valid = 1'b1;
        cmd_line  = cmd_index;
        case (op)
            CMD_STORE_ALLOC: begin
                sq_alloc = 1'b1;
                for (k = 1; k < a; k++) begin
                    next_cycle();
                    sq_alloc = 1'b1;
                end
            end
            CMD_STORE_RESOLVE: begin
                sq_resolve      = 1'b1;
                sq_resolve_idx  = sq_idx_t'(a);
                sq_resolve_addr = b;
                sq_resolve_data = c;
            end
            CMD_COMMIT: begin
                store_commit = 1'b1;
            end
            CMD_LOAD_ALLOC: begin
                lb_alloc = 1'b1;
                for (k = 1; k < a; k++) begin
                    next_cycle();
                    lb_alloc = 1'b1;
                end
            end
            CMD_LOAD_RESOLVE: begin
                lb_resolve      = 1'b1;
                lb_resolve_idx  = lb_idx_t'(a);
                lb_resolve_addr = b;
                lb_resolve_tag  = load_tag_t'(c);
            end
            CMD_WAIT: begin
                for (k = 0; k < a; k++) begin
                    next_cycle();
                end
            end
            default: begin
            end
        endcase
    endtask

    initial begin : main
        int i;
        clock           = 1'b0;
        reset           = 1'b1;
        sq_alloc        = 1'b0;
        sq_resolve      = 1'b0;
        sq_resolve_idx  = '0;
        sq_resolve_addr = '0;
        sq_resolve_data = '0;
        store_commit    = 1'b0;
        lb_alloc        = 1'b0;
        lb_resolve      = 1'b0;
        lb_resolve_idx  = '0;
        lb_resolve_addr = '0;
        lb_resolve_tag  = '0;
        cmd_valid       = 1'b0;
        cmd_line        = 0;
        lines_ready     = 1'b0;
        $readmemh("lsq_testdata.txt", cmd_mem);
        num_lines = 0;
        while (num_lines < MAX_LINES && !$isunknown(cmd_mem[4*num_lines]) &&
               cmd_mem[4*num_lines] != CMD_STOP) begin
            num_lines++;
        end
        lines_ready = 1'b1;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (i = 0; i < num_lines; i++) begin
            run_command(i);
        end
        next_cycle();
        next_cycle();
        if (num_lines == 0) begin
            $display("No commands were read from lsq_testdata.txt");
        end
        $display("Tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (num_lines > 0 && tests_failed == 0 && error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Run limit scales with the length of the command file
    initial begin : watchdog
        wait (lines_ready);
        #(CLOCK_PERIOD * (CYCLES_PER_LINE * num_lines + 10));
        $display("Watchdog expired at %0t, the command sequence did not finish", $time);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: lsq_testdata.txt
// op a b c: 1 st alloc n, 2 st resolve idx addr data, 3 commit, 4 ld alloc n, 5 ld resolve
// slot addr tag, 6 wait n, 7 result tag data fwd, 8 write addr data, 9 full sq lb, a end, f stop
1 1 0 0                     // test 1, forward from a resolved store
2 0 00000100 11112222
4 1 0 0
7 01 11112222 1
5 0 00000100 01
8 00000100 11112222 0
3 0 0 0
a 1 0 0
4 1 0 0                     // test 2, no older store
7 02 5a5a0200 0
5 0 00000200 02
a 2 0 0
1 2 0 0                     // test 3, load waits behind unresolved stores
4 1 0 0
5 0 00000300 03
6 a 0 0
2 1 00000300 aaaa0001
2 2 00000300 bbbb0002
7 03 bbbb0002 1
a 3 0 0
8 00000300 aaaa0001 0       // test 4, drain order and load from memory
8 00000300 bbbb0002 0
3 0 0 0
3 0 0 0
6 14 0 0
4 1 0 0
7 04 bbbb0002 0
5 0 00000300 04
a 4 0 0
4 4 0 0                     // test 5, full flags
9 0 1 0
7 05 5a5a0800 0
5 0 00000800 05
6 4 0 0
9 0 0 0
1 8 0 0
9 1 0 0
2 3 00000700 12340003
8 00000700 12340003 0
3 0 0 0
6 c 0 0
9 0 0 0
a 5 0 0
f 0 0 0

// File: lsq_top.sv
`include "lsq_params.svh"

module lsq_top import lsq_entry_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    // Store side of the core
    input  logic      sq_alloc,
    output sq_idx_t   sq_alloc_idx,
    output logic      sq_full,
    input  logic      sq_resolve,
    input  sq_idx_t   sq_resolve_idx,
    input  word_t     sq_resolve_addr,
    input  word_t     sq_resolve_data,
    input  logic      store_commit,
    // Load side of the core
    input  logic      lb_alloc,
    output lb_idx_t   lb_alloc_idx,
    output logic      lb_full,
    input  logic      lb_resolve,
    input  lb_idx_t   lb_resolve_idx,
    input  word_t     lb_resolve_addr,
    input  load_tag_t lb_resolve_tag,
    output logic      result_valid,
    output load_tag_t result_tag,
    output word_t     result_data,
    output logic      result_forwarded,
    // Wishbone master
    output logic      wb_cyc,
    output logic      wb_stb,
    output logic      wb_we,
    output word_t     wb_addr,
    output word_t     wb_write_data,
    input  word_t     wb_read_data,
    input  logic      wb_ack
);

    sq_idx_t                        sq_head;
    sq_idx_t                        oldest_unresolved;
    logic                           all_resolved;
    word_t [`LSQ_SQ_DEPTH-1:0]      entry_addr;
    word_t [`LSQ_SQ_DEPTH-1:0]      entry_data;
    logic  [`LSQ_SQ_DEPTH-1:0]      entry_resolved;
    logic                           drain_ready;
    word_t                          drain_addr;
    word_t                          drain_data;
    logic                           drain_done;
    logic                           issue_ready;
    logic                           issue_valid;
    word_t                          issue_addr;
    sq_idx_t                        issue_age;
    load_tag_t                      issue_tag;
    logic                           fwd_match;
    word_t                          fwd_data;

    store_queue i_store_queue (.*);

    load_buffer i_load_buffer (.*);

    store_forward i_store_forward (.*);

    lsq_mem_control i_lsq_mem_control (.*);

endmodule

// File: store_forward.sv
`include "lsq_params.svh"

module store_forward import lsq_entry_pkg::*; (
    input  sq_idx_t                         sq_head,
    input  sq_idx_t                         sq_alloc_idx,
    input  word_t [`LSQ_SQ_DEPTH-1:0]       entry_addr,
    input  word_t [`LSQ_SQ_DEPTH-1:0]       entry_data,
    input  logic  [`LSQ_SQ_DEPTH-1:0]       entry_resolved,
    input  logic                            issue_valid,
    input  word_t                           issue_addr,
    input  sq_idx_t                         issue_age,
    output logic                            fwd_match,
    output word_t                           fwd_data
);

    sq_idx_t age_dist;
    sq_idx_t tail_dist;
    logic    hit;

    // Stores older than the load sit between head and its age
    assign age_dist  = sq_idx_t'(issue_age - sq_head);
    assign tail_dist = sq_idx_t'(sq_alloc_idx - sq_head);

    // Walk oldest to youngest so the youngest match is kept
    always_comb begin : search
        sq_idx_t idx;
        logic    in_ring;
        hit      = 1'b0;
        fwd_data = '0;
        for (int k = 0; k < `LSQ_SQ_DEPTH; k++) begin
            idx = sq_idx_t'(sq_head + k);
            // tail equal to head is either empty or full
            in_ring = k < tail_dist || tail_dist == '0;
            if (k < age_dist && in_ring && entry_resolved[idx] &&
                entry_addr[idx] == issue_addr) begin
                hit      = 1'b1;
                fwd_data = entry_data[idx];
            end
        end
    end

    assign fwd_match = issue_valid && hit;

endmodule

// File: store_queue.sv
`include "lsq_params.svh"

module store_queue import lsq_entry_pkg::*; (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            sq_alloc,
    input  logic                            sq_resolve,
    input  sq_idx_t                         sq_resolve_idx,
    input  word_t                           sq_resolve_addr,
    input  word_t                           sq_resolve_data,
    input  logic                            store_commit,
    input  logic                            drain_done,
    output sq_idx_t                         sq_alloc_idx,
    output logic                            sq_full,
    output sq_idx_t                         sq_head,
    output sq_idx_t                         oldest_unresolved,
    output logic                            all_resolved,
    output word_t [`LSQ_SQ_DEPTH-1:0]       entry_addr,
    output word_t [`LSQ_SQ_DEPTH-1:0]       entry_data,
    output logic  [`LSQ_SQ_DEPTH-1:0]       entry_resolved,
    output logic                            drain_ready,
    output word_t                           drain_addr,
    output word_t                           drain_data
);

    sq_idx_t   head;
    sq_idx_t   tail;
    sq_count_t count;
    sq_count_t committed;
    sq_idx_t   scan_idx;
    logic      scan_found;
    logic      resolve_in_range;
    logic      resolve_ok;

    assign sq_alloc_idx = tail;
    assign sq_head      = head;
    assign sq_full      = count == `LSQ_SQ_DEPTH;

    // Head store goes out once committed and resolved
    assign drain_ready = committed != '0 && entry_resolved[head];
    assign drain_addr  = entry_addr[head];
    assign drain_data  = entry_data[head];

    assign resolve_in_range = sq_count_t'(sq_idx_t'(sq_resolve_idx - head)) < count;
    assign resolve_ok       = sq_resolve && resolve_in_range && !entry_resolved[sq_resolve_idx];

    ////////////////////////////////////////////////////////////
    // Oldest unresolved store
    ////////////////////////////////////////////////////////////

    // Scan from the tail end back so the oldest hit is written last
    always_comb begin
        scan_idx   = head;
        scan_found = 1'b0;
        for (int k = `LSQ_SQ_DEPTH - 1; k >= 0; k--) begin
            if (k < count && !entry_resolved[sq_idx_t'(head + k)]) begin
                scan_idx   = sq_idx_t'(head + k);
                scan_found = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointers, counters and resolved flags
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head              <= '0;
            tail              <= '0;
            count             <= '0;
            committed         <= '0;
            entry_resolved    <= '0;
            oldest_unresolved <= '0;
            all_resolved      <= 1'b1;
        end else begin
            oldest_unresolved <= scan_idx;
            all_resolved      <= !scan_found;
            if (sq_alloc) begin
                entry_resolved[tail] <= 1'b0;
                tail                 <= tail + 1'b1;
            end
            if (resolve_ok) begin
                entry_resolved[sq_resolve_idx] <= 1'b1;
            end
            // Retire the head at the end of its bus write
            if (drain_done) begin
                entry_resolved[head] <= 1'b0;
                head                 <= head + 1'b1;
            end
            count     <= count + sq_count_t'(sq_alloc) - sq_count_t'(drain_done);
            committed <= committed + sq_count_t'(store_commit) - sq_count_t'(drain_done);
        end
    end

    // Address and data of each entry
    always_ff @(posedge clock) begin
        if (resolve_ok) begin
            entry_addr[sq_resolve_idx] <= sq_resolve_addr;
            entry_data[sq_resolve_idx] <= sq_resolve_data;
        end
    end

    a_no_alloc_when_full: assert property (
        @(posedge clock) disable iff (reset) sq_alloc |-> !sq_full);

    a_resolve_in_ring: assert property (
        @(posedge clock) disable iff (reset) sq_resolve |-> resolve_in_range);

    // Bus side only finishes a drain that was offered
    a_drain_done_ready: assert property (
        @(posedge clock) disable iff (reset) drain_done |-> drain_ready);

endmodule
